// ==== src/pi_pkg.sv ====
// Shared definitions for the peripheral subsystem: bus widths, device map,
// slave encoding and the structs carried between the pipeline stages.
// Every RTL file and the testbench refer to these by scoped name.

package pi_pkg;

	// Bus widths
	localparam int PI_ADDR_W = 16;
	localparam int PI_DATA_W = 32;

	localparam int GPIO_COUNT = 16;

	// Device map, contiguous from word address zero
	localparam logic [PI_ADDR_W-1:0] DEVTBL_BASE  = 16'd0;
	localparam logic [PI_ADDR_W-1:0] DEVTBL_MAPSZ = 16'd256;
	localparam logic [PI_ADDR_W-1:0] GPIO_BASE    = 16'd256;
	localparam logic [PI_ADDR_W-1:0] GPIO_MAPSZ   = 16'd16;

	// Everything past the GPIO block belongs to the invalid-device catcher
	localparam logic [PI_ADDR_W-1:0] INVALID_BASE  = GPIO_BASE + GPIO_MAPSZ;
	localparam logic [PI_ADDR_W-1:0] INVALID_MAPSZ = 16'd0;

	// Register offsets inside the devices
	localparam logic [PI_ADDR_W-1:0] DEVTBL_RSTCTRL_OFS = 16'd255;
	localparam logic [PI_ADDR_W-1:0] DEVTBL_ENTRY_CNT   = 16'd3;
	localparam logic [PI_ADDR_W-1:0] GPIO_OUT_OFS       = 16'd0;
	localparam logic [PI_ADDR_W-1:0] GPIO_IN_OFS        = 16'd1;

	// Device ids and interrupt use, as reported by the device table
	localparam logic [7:0] DEV_ID_DEVTBL  = 8'd7;
	localparam logic [7:0] DEV_ID_GPIO    = 8'd6;
	localparam logic [7:0] DEV_ID_INVALID = 8'd0;

	localparam logic DEV_IRQ_DEVTBL  = 1'b0;
	localparam logic DEV_IRQ_GPIO    = 1'b1;
	localparam logic DEV_IRQ_INVALID = 1'b0;

	// Software reset stretch
	localparam int RST_HOLD_CYCLES = 16;
	localparam int RST_CNT_W       = $clog2(RST_HOLD_CYCLES + 1);
	localparam logic [RST_CNT_W-1:0] RST_HOLD_LOAD = RST_CNT_W'(RST_HOLD_CYCLES);

	// Slave select, its value is also the device table index
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_GPIO    = 2'd1,
		SLV_INVALID = 2'd2
	} pi_slave_e;

	typedef struct packed {
		logic                 valid;
		logic                 we;
		logic [PI_ADDR_W-1:0] addr;
		logic [PI_DATA_W-1:0] data;
	} pi_req_t;

	typedef struct packed {
		logic                 valid;
		logic                 we;
		pi_slave_e            slave;
		logic [PI_ADDR_W-1:0] offset;
		logic [PI_DATA_W-1:0] data;
	} pi_dec_t;

	typedef struct packed {
		logic                 valid;
		logic                 err;
		logic [PI_DATA_W-1:0] data;
	} pi_rsp_t;

	typedef struct packed {
		logic valid;
		logic rst0;
		logic rst1;
	} pi_swrst_t;

	// Entry word: map size in 31:16, interrupt use in bit 8, id in 7:0
	function automatic logic [PI_DATA_W-1:0] devtbl_entry(pi_slave_e slv);
		logic [PI_DATA_W-1:0] entry;
		entry = '0;
		case (slv)
			SLV_DEVTBL:  entry = {DEVTBL_MAPSZ, 7'd0, DEV_IRQ_DEVTBL, DEV_ID_DEVTBL};
			SLV_GPIO:    entry = {GPIO_MAPSZ, 7'd0, DEV_IRQ_GPIO, DEV_ID_GPIO};
			default:     entry = {INVALID_MAPSZ, 7'd0, DEV_IRQ_INVALID, DEV_ID_INVALID};
		endcase
		return entry;
	endfunction

endpackage

// ==== src/pi_decode_stage.sv ====
// First pipeline stage of the peripheral subsystem.
// Registers each request together with its target slave and the word
// offset inside that slave, one request per cycle.

`timescale 1ns/1ps

module pi_decode_stage (
	input  logic            clk_2x_w,
	input  logic            devtbl_rst2_w,
	input  pi_pkg::pi_req_t req_i,
	output pi_pkg::pi_dec_t dec_o
);

	logic [pi_pkg::PI_ADDR_W-1:0] devtbl_ofs;
	logic [pi_pkg::PI_ADDR_W-1:0] gpio_ofs;
	logic [pi_pkg::PI_ADDR_W-1:0] invalid_ofs;
	logic                         devtbl_hit;
	logic                         gpio_hit;
	pi_pkg::pi_dec_t              dec_d;
	pi_pkg::pi_dec_t              dec_q;

	// Offset against every base in the map
	assign devtbl_ofs  = req_i.addr - pi_pkg::DEVTBL_BASE;
	assign gpio_ofs    = req_i.addr - pi_pkg::GPIO_BASE;
	assign invalid_ofs = req_i.addr - pi_pkg::INVALID_BASE;

	// An address below a base wraps to a large offset and misses that window
	assign devtbl_hit = (devtbl_ofs < pi_pkg::DEVTBL_MAPSZ);
	assign gpio_hit   = (gpio_ofs < pi_pkg::GPIO_MAPSZ);

	always_comb begin
		dec_d.valid = req_i.valid;
		dec_d.we    = req_i.we;
		dec_d.data  = req_i.data;
		if (devtbl_hit) begin
			dec_d.slave  = pi_pkg::SLV_DEVTBL;
			dec_d.offset = devtbl_ofs;
		end else if (gpio_hit) begin
			dec_d.slave  = pi_pkg::SLV_GPIO;
			dec_d.offset = gpio_ofs;
		end else begin
			// Beyond the last device
			dec_d.slave  = pi_pkg::SLV_INVALID;
			dec_d.offset = invalid_ofs;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		dec_q <= dec_d;
		if (devtbl_rst2_w) begin
			dec_q.valid <= 1'b0;
		end
	end

	assign dec_o = dec_q;

endmodule

// ==== src/pi_access_stage.sv ====
// Second pipeline stage of the peripheral subsystem.
// Holds the device table, the GPIO output register and the invalid-device
// catcher, registers one response per decoded request and forwards writes
// of the reset control word to the reset sequencer.

`timescale 1ns/1ps

module pi_access_stage (
	input  logic                          clk_2x_w,
	input  logic                          devtbl_rst2_w,
	input  pi_pkg::pi_dec_t               dec_i,
	input  logic                          soc_rst_i,
	input  logic [pi_pkg::GPIO_COUNT-1:0] gp_i,
	output logic [pi_pkg::GPIO_COUNT-1:0] gp_o,
	output pi_pkg::pi_rsp_t               rsp_o,
	output pi_pkg::pi_swrst_t             swrst_o
);

	logic                          devtbl_sel;
	logic                          gpio_sel;
	logic                          rstctrl_wr;
	logic                          gpio_out_wr;
	logic [pi_pkg::PI_DATA_W-1:0]  devtbl_rdata;
	logic [pi_pkg::PI_DATA_W-1:0]  gpio_rdata;
	logic [pi_pkg::GPIO_COUNT-1:0] gpio_out_q;
	pi_pkg::pi_rsp_t               rsp_d;
	pi_pkg::pi_rsp_t               rsp_q;
	pi_pkg::pi_swrst_t             swrst_d;
	pi_pkg::pi_swrst_t             swrst_q;

	assign devtbl_sel = dec_i.valid && (dec_i.slave == pi_pkg::SLV_DEVTBL);
	assign gpio_sel   = dec_i.valid && (dec_i.slave == pi_pkg::SLV_GPIO);

	assign rstctrl_wr  = devtbl_sel && dec_i.we &&
		(dec_i.offset == pi_pkg::DEVTBL_RSTCTRL_OFS);
	assign gpio_out_wr = gpio_sel && dec_i.we && (dec_i.offset == pi_pkg::GPIO_OUT_OFS);

	// Device table, one entry word per slave and zeros elsewhere
	always_comb begin
		devtbl_rdata = '0;
		if (dec_i.offset < pi_pkg::DEVTBL_ENTRY_CNT) begin
			devtbl_rdata = pi_pkg::devtbl_entry(pi_pkg::pi_slave_e'(dec_i.offset[1:0]));
		end
	end

	// GPIO read side, pins are zero extended
	always_comb begin
		gpio_rdata = '0;
		case (dec_i.offset)
			pi_pkg::GPIO_OUT_OFS: gpio_rdata[pi_pkg::GPIO_COUNT-1:0] = gpio_out_q;
			pi_pkg::GPIO_IN_OFS:  gpio_rdata[pi_pkg::GPIO_COUNT-1:0] = gp_i;
			default:              gpio_rdata = '0;
		endcase
	end

	// Response word; writes answer with data 0
	always_comb begin
		rsp_d.valid = dec_i.valid;
		rsp_d.err   = 1'b0;
		rsp_d.data  = '0;
		case (dec_i.slave)
			pi_pkg::SLV_DEVTBL: begin
				if (!dec_i.we) begin
					rsp_d.data = devtbl_rdata;
				end
			end
			pi_pkg::SLV_GPIO: begin
				if (!dec_i.we) begin
					rsp_d.data = gpio_rdata;
				end
			end
			default: begin
				// Access outside the map
				rsp_d.err = dec_i.valid;
			end
		endcase
	end

	// Reset request taken from the two low data bits
	always_comb begin
		swrst_d.valid = rstctrl_wr;
		swrst_d.rst0  = dec_i.data[0];
		swrst_d.rst1  = dec_i.data[1];
	end

	always_ff @(posedge clk_2x_w) begin
		rsp_q   <= rsp_d;
		swrst_q <= swrst_d;
		if (devtbl_rst2_w) begin
			rsp_q.valid   <= 1'b0;
			rsp_q.err     <= 1'b0;
			swrst_q.valid <= 1'b0;
		end
	end

	// Output pins stay low and ignore writes while the subsystem is in reset
	always_ff @(posedge clk_2x_w) begin
		if (devtbl_rst2_w || soc_rst_i) begin
			gpio_out_q <= '0;
		end else if (gpio_out_wr) begin
			gpio_out_q <= dec_i.data[pi_pkg::GPIO_COUNT-1:0];
		end
	end

	assign gp_o    = gpio_out_q;
	assign rsp_o   = rsp_q;
	assign swrst_o = swrst_q;

endmodule

// ==== src/pi_reset_seq.sv ====
// Reset sequencer of the peripheral subsystem.
// Turns software reset requests into a stretched subsystem reset, a one
// cycle cold reset pulse and a power-off level held until external reset.

`timescale 1ns/1ps

module pi_reset_seq (
	input  logic              clk_2x_w,
	input  logic              devtbl_rst2_w,
	input  pi_pkg::pi_swrst_t swrst_i,
	output logic              soc_rst_o,
	output logic              cold_rst_o,
	output logic              pwroff_o
);

	logic                         sw_cold;
	logic                         sw_warm;
	logic                         sw_pwroff;
	logic [pi_pkg::RST_CNT_W-1:0] hold_cnt_q;
	logic                         cold_q;
	logic                         pwroff_q;

	// Both bits is cold, rst1 alone is warm, rst0 alone is power-off
	assign sw_cold   = swrst_i.valid && swrst_i.rst0 && swrst_i.rst1;
	assign sw_warm   = swrst_i.valid && !swrst_i.rst0 && swrst_i.rst1;
	assign sw_pwroff = swrst_i.valid && swrst_i.rst0 && !swrst_i.rst1;

	// Hold counter, reloaded by external reset and by cold or warm requests
	always_ff @(posedge clk_2x_w) begin
		if (devtbl_rst2_w) begin
			hold_cnt_q <= pi_pkg::RST_HOLD_LOAD;
		end else if (sw_cold || sw_warm) begin
			hold_cnt_q <= pi_pkg::RST_HOLD_LOAD;
		end else if (hold_cnt_q != '0) begin
			hold_cnt_q <= hold_cnt_q - 1'b1;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (devtbl_rst2_w) begin
			cold_q   <= 1'b0;
			pwroff_q <= 1'b0;
		end else begin
			cold_q <= sw_cold;
			// Latched, only the external reset releases it
			if (sw_pwroff) begin
				pwroff_q <= 1'b1;
			end
		end
	end

	// External reset counts too, so the output is high before the first edge
	assign soc_rst_o  = devtbl_rst2_w || (hold_cnt_q != '0);
	assign cold_rst_o = cold_q;
	assign pwroff_o   = pwroff_q;

endmodule

// ==== src/pi_soc_top.sv ====
// Top level of the peripheral subsystem.
// Chains the decode stage, the access stage and the reset sequencer; the
// subsystem reset from the sequencer also holds the GPIO block.

`timescale 1ns/1ps

module pi_soc_top (
	input  logic                          clk_2x_w,
	input  logic                          devtbl_rst2_w,
	input  pi_pkg::pi_req_t               req_i,
	input  logic [pi_pkg::GPIO_COUNT-1:0] gp_i,
	output logic [pi_pkg::GPIO_COUNT-1:0] gp_o,
	output pi_pkg::pi_rsp_t               rsp_o,
	output logic                          soc_rst_o,
	output logic                          cold_rst_o,
	output logic                          pwroff_o
);

	pi_pkg::pi_dec_t   dec_w;
	pi_pkg::pi_swrst_t swrst_w;

	pi_decode_stage i_pi_decode_stage (
		.clk_2x_w      (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.req_i         (req_i),
		.dec_o         (dec_w)
	);

	pi_access_stage i_pi_access_stage (
		.clk_2x_w      (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.dec_i         (dec_w),
		.soc_rst_i     (soc_rst_o),
		.gp_i          (gp_i),
		.gp_o          (gp_o),
		.rsp_o         (rsp_o),
		.swrst_o       (swrst_w)
	);

	// Acts on a reset request one edge after the access stage registers it
	pi_reset_seq i_pi_reset_seq (
		.clk_2x_w      (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.swrst_i       (swrst_w),
		.soc_rst_o     (soc_rst_o),
		.cold_rst_o    (cold_rst_o),
		.pwroff_o      (pwroff_o)
	);

endmodule

// ==== verif/pi_soc_properties.sv ====
// Concurrent checks on the peripheral subsystem top level.
// Bound into pi_soc_top to watch the request, response and reset pins.

`timescale 1ns/1ps

module pi_soc_properties (
	input logic            clk_2x_w,
	input logic            devtbl_rst2_w,
	input pi_pkg::pi_req_t req_i,
	input pi_pkg::pi_rsp_t rsp_i,
	input logic            soc_rst_i,
	input logic            pwroff_i
);

	// One cycle in each pipeline stage
	rsp_latency_a: assert property (@(posedge clk_2x_w) disable iff (devtbl_rst2_w)
		req_i.valid |-> ##2 rsp_i.valid)
		else $error("no valid response two cycles after a request");

	err_needs_valid_a: assert property (@(posedge clk_2x_w) disable iff (devtbl_rst2_w)
		!(rsp_i.err && !rsp_i.valid))
		else $error("response err high while valid is low");

	rst_holds_soc_a: assert property (@(posedge clk_2x_w)
		devtbl_rst2_w |-> soc_rst_i)
		else $error("soc_rst_o low during external reset");

	// Power-off is a latch that only the external reset releases
	pwroff_latched_a: assert property (@(posedge clk_2x_w)
		pwroff_i && !devtbl_rst2_w |=> pwroff_i)
		else $error("pwroff_o dropped without external reset");

endmodule

bind pi_soc_top pi_soc_properties i_pi_soc_properties (
	.clk_2x_w      (clk_2x_w),
	.devtbl_rst2_w (devtbl_rst2_w),
	.req_i         (req_i),
	.rsp_i         (rsp_o),
	.soc_rst_i     (soc_rst_o),
	.pwroff_i      (pwroff_o)
);

// ==== verif/pi_soc_tb.sv ====
// Testbench for the peripheral subsystem top level.
// Issues register requests, predicts each response with a reference model
// and checks responses, GPIO pins and the reset outputs.

`timescale 1ns/1ps

module pi_soc_tb;

	localparam int CLK_PERIOD    = 4;
	localparam int RST_CYCLES    = 16;
	localparam int NUM_GPIO      = 40;
	localparam int NUM_INVALID   = 30;
	localparam int NUM_MIXED     = 80;
	localparam int TEST_CYCLES   = 2 * (RST_CYCLES + pi_pkg::RST_HOLD_CYCLES) +
		8 * NUM_GPIO + NUM_INVALID + NUM_MIXED + 150;
	localparam int MARGIN_CYCLES = 200;
	localparam int unsigned SEED = 32'h7fc3a55b;

	localparam logic [pi_pkg::PI_ADDR_W-1:0] GPIO_OUT_ADDR = pi_pkg::GPIO_BASE;
	localparam logic [pi_pkg::PI_ADDR_W-1:0] GPIO_IN_ADDR  = pi_pkg::GPIO_BASE + 16'd1;
	localparam logic [pi_pkg::PI_ADDR_W-1:0] RSTCTRL_ADDR  =
		pi_pkg::DEVTBL_BASE + pi_pkg::DEVTBL_RSTCTRL_OFS;
	localparam logic [pi_pkg::PI_ADDR_W-1:0] INVALID_START =
		pi_pkg::GPIO_BASE + pi_pkg::GPIO_MAPSZ;

	typedef struct packed {
		logic [31:0]     due;
		pi_pkg::pi_rsp_t rsp;
	} exp_t;

	logic                          clk_2x_w;
	logic                          devtbl_rst2_w;
	pi_pkg::pi_req_t               req;
	logic [pi_pkg::GPIO_COUNT-1:0] gp_in;
	logic [pi_pkg::GPIO_COUNT-1:0] gp_out;
	pi_pkg::pi_rsp_t               rsp;
	logic                          soc_rst;
	logic                          cold_rst;
	logic                          pwroff;
	logic [pi_pkg::GPIO_COUNT-1:0] gpio_model;
	exp_t                          exp_q[$];
	int                            cyc = 0;
	int                            mismatch_cnt = 0;
	int                            other_err_cnt = 0;
	int unsigned                   seed_val;

	pi_soc_top i_pi_soc_top (
		.clk_2x_w      (clk_2x_w),
		.devtbl_rst2_w (devtbl_rst2_w),
		.req_i         (req),
		.gp_i          (gp_in),
		.gp_o          (gp_out),
		.rsp_o         (rsp),
		.soc_rst_o     (soc_rst),
		.cold_rst_o    (cold_rst),
		.pwroff_o      (pwroff)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #(CLK_PERIOD / 2) clk_2x_w = ~clk_2x_w;
	end

	always @(posedge clk_2x_w) cyc <= cyc + 1;

	// Expected response from the device map and register rules
	function automatic pi_pkg::pi_rsp_t ref_rsp(input pi_pkg::pi_req_t r,
		input logic [pi_pkg::GPIO_COUNT-1:0] pins, input logic gpio_held);
		pi_pkg::pi_rsp_t e;
		logic [pi_pkg::PI_ADDR_W-1:0] ofs;
		e.valid = 1'b1;
		e.err   = 1'b0;
		e.data  = '0;
		if (r.addr < pi_pkg::GPIO_BASE) begin
			if (!r.we) begin
				case (r.addr)
					16'd0:   e.data = {pi_pkg::DEVTBL_MAPSZ, 8'h00, pi_pkg::DEV_ID_DEVTBL};
					16'd1:   e.data = {pi_pkg::GPIO_MAPSZ, 8'h01, pi_pkg::DEV_ID_GPIO};
					16'd2:   e.data = {16'd0, 8'h00, pi_pkg::DEV_ID_INVALID};
					default: e.data = '0;
				endcase
			end
		end else if (r.addr < INVALID_START) begin
			ofs = r.addr - pi_pkg::GPIO_BASE;
			if (r.we) begin
				if (ofs == 16'd0 && !gpio_held) begin
					gpio_model = r.data[pi_pkg::GPIO_COUNT-1:0];
				end
			end else if (ofs == 16'd0) begin
				e.data = 32'(gpio_model);
			end else if (ofs == 16'd1) begin
				e.data = 32'(pins);
			end
		end else begin
			e.err = 1'b1;
		end
		return e;
	endfunction

	task automatic check_rsp(input pi_pkg::pi_rsp_t exp_rsp, input pi_pkg::pi_rsp_t act_rsp);
		if (act_rsp !== exp_rsp) begin
			$display("MISMATCH at %0t: rsp_o expected %h actual %h", $time, exp_rsp, act_rsp);
			mismatch_cnt++;
		end
	endtask

	task automatic check_gpio(input string name, input logic [pi_pkg::GPIO_COUNT-1:0] exp_val,
		input logic [pi_pkg::GPIO_COUNT-1:0] act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
			mismatch_cnt++;
		end
	endtask

	task automatic check_level(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val) begin
			$display("MISMATCH at %0t: %s expected %b actual %b", $time, name, exp_val, act_val);
			mismatch_cnt++;
		end
	endtask

	// Responses are due two cycles after their request
	always @(negedge clk_2x_w) begin : rsp_checker
		exp_t item;
		if (!devtbl_rst2_w) begin
			if (exp_q.size() != 0 && exp_q[0].due == 32'(cyc)) begin
				item = exp_q.pop_front();
				if (rsp.valid !== 1'b1) begin
					$display("ERROR at %0t: no response for a request due in cycle %0d",
						$time, cyc);
					other_err_cnt++;
				end else begin
					check_rsp(item.rsp, rsp);
				end
			end else if (rsp.valid !== 1'b0) begin
				$display("ERROR at %0t: response valid with no request pending", $time);
				other_err_cnt++;
			end
		end
	end

	task automatic issue_req(input logic we, input logic [pi_pkg::PI_ADDR_W-1:0] addr,
		input logic [pi_pkg::PI_DATA_W-1:0] data, input logic gpio_held);
		exp_t item;
		@(posedge clk_2x_w);
		#1;
		req.valid = 1'b1;
		req.we    = we;
		req.addr  = addr;
		req.data  = data;
		item.due  = 32'(cyc + 2);
		item.rsp  = ref_rsp(req, gp_in, gpio_held);
		exp_q.push_back(item);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk_2x_w);
			#1;
			req.valid = 1'b0;
		end
	endtask

	task automatic drain_responses();
		while (exp_q.size() != 0) begin
			idle_cycles(1);
		end
	endtask

	// Called at time zero or just after a rising edge
	task automatic apply_reset();
		devtbl_rst2_w = 1'b1;
		req.valid     = 1'b0;
		repeat (RST_CYCLES) begin
			@(posedge clk_2x_w);
			#1;
		end
		check_level("pwroff_o", 1'b0, pwroff);
		check_level("soc_rst_o", 1'b1, soc_rst);
		devtbl_rst2_w = 1'b0;
		gpio_model    = '0;
	endtask

	// Subsystem reset stays high for the hold time after the external reset falls
	task automatic wait_soc_rst_release();
		int n;
		n = 0;
		while (soc_rst === 1'b1 && n < 2 * pi_pkg::RST_HOLD_CYCLES) begin
			idle_cycles(1);
			n++;
		end
		if (soc_rst !== 1'b0) begin
			$display("ERROR at %0t: soc_rst_o still high long after the hold time", $time);
			other_err_cnt++;
		end else if (n != pi_pkg::RST_HOLD_CYCLES) begin
			$display("MISMATCH at %0t: soc_rst_o hold cycles expected %0d actual %0d",
				$time, pi_pkg::RST_HOLD_CYCLES, n);
			mismatch_cnt++;
		end
	endtask

	task automatic run_devtbl_reads();
		int i;
		for (i = 0; i < 4; i++) begin
			issue_req(1'b0, 16'(i), 32'd0, 1'b0);
		end
		issue_req(1'b0, 16'd128, 32'd0, 1'b0);
		issue_req(1'b0, RSTCTRL_ADDR, 32'd0, 1'b0);
		// Writes away from the reset control word change nothing
		issue_req(1'b1, 16'd1, 32'hffff_ffff, 1'b0);
		issue_req(1'b0, 16'd1, 32'd0, 1'b0);
		drain_responses();
	endtask

	task automatic run_gpio();
		int i;
		for (i = 0; i < NUM_GPIO; i++) begin
			gp_in = 16'($urandom);
			issue_req(1'b1, GPIO_OUT_ADDR, $urandom, 1'b0);
			issue_req(1'b0, GPIO_OUT_ADDR, 32'd0, 1'b0);
			issue_req(1'b0, GPIO_IN_ADDR, 32'd0, 1'b0);
			issue_req(1'b0, GPIO_OUT_ADDR + 16'($urandom_range(2, 15)), 32'd0, 1'b0);
			drain_responses();
			check_gpio("gp_o", gpio_model, gp_out);
		end
	endtask

	task automatic run_invalid_and_mixed();
		int i;
		for (i = 0; i < NUM_INVALID; i++) begin
			issue_req(1'($urandom_range(0, 1)),
				16'($urandom_range(32'(INVALID_START), 32'hffff)), $urandom, 1'b0);
		end
		drain_responses();
		gp_in = 16'($urandom);
		// Back to back stream with the pins held still throughout
		for (i = 0; i < NUM_MIXED; i++) begin
			case ($urandom_range(0, 3))
				0: issue_req(1'b0, 16'($urandom_range(0, 255)), 32'd0, 1'b0);
				1: issue_req(1'b1, GPIO_OUT_ADDR, $urandom, 1'b0);
				2: issue_req(1'b0, GPIO_OUT_ADDR + 16'($urandom_range(0, 15)), 32'd0, 1'b0);
				default: issue_req(1'($urandom_range(0, 1)),
					16'($urandom_range(32'(INVALID_START), 32'hffff)), $urandom, 1'b0);
			endcase
		end
		drain_responses();
		check_gpio("gp_o", gpio_model, gp_out);
	endtask

	// Code bit 0 is rst0 and bit 1 is rst1
	task automatic run_sw_reset(input logic [1:0] code, input logic expect_cold);
		int d;
		issue_req(1'b1, GPIO_OUT_ADDR, 32'h0000_a5c3, 1'b0);
		drain_responses();
		check_gpio("gp_o", 16'ha5c3, gp_out);
		issue_req(1'b1, RSTCTRL_ADDR, 32'(code), 1'b0);
		gpio_model = '0;
		for (d = 1; d <= 3 + pi_pkg::RST_HOLD_CYCLES + 2; d++) begin
			if (d == 5) begin
				issue_req(1'b1, GPIO_OUT_ADDR, 32'h0000_ffff, 1'b1);
			end else begin
				idle_cycles(1);
			end
			@(negedge clk_2x_w);
			check_level("soc_rst_o", d >= 3 && d < 3 + pi_pkg::RST_HOLD_CYCLES, soc_rst);
			check_level("cold_rst_o", expect_cold && d == 3, cold_rst);
			check_level("pwroff_o", 1'b0, pwroff);
			if (d >= 4) begin
				check_gpio("gp_o", '0, gp_out);
			end
		end
		issue_req(1'b0, GPIO_OUT_ADDR, 32'd0, 1'b0);
		drain_responses();
	endtask

	task automatic run_pwroff();
		int d;
		issue_req(1'b1, RSTCTRL_ADDR, 32'd1, 1'b0);
		for (d = 1; d <= 12; d++) begin
			idle_cycles(1);
			@(negedge clk_2x_w);
			check_level("pwroff_o", d >= 3, pwroff);
			check_level("soc_rst_o", 1'b0, soc_rst);
		end
		drain_responses();
		idle_cycles(1);
		apply_reset();
		wait_soc_rst_release();
		check_level("pwroff_o", 1'b0, pwroff);
	endtask

	initial begin
		seed_val      = $urandom(SEED);
		devtbl_rst2_w = 1'b1;
		req           = '0;
		gp_in         = '0;
		gpio_model    = '0;
		apply_reset();
		wait_soc_rst_release();
		run_devtbl_reads();
		run_gpio();
		run_invalid_and_mixed();
		run_sw_reset(2'b10, 1'b0);
		run_sw_reset(2'b11, 1'b1);
		run_pwroff();
		drain_responses();
		idle_cycles(4);
		$display("Error counts: %0d mismatches, %0d other failures",
			mismatch_cnt, other_err_cnt);
		if (mismatch_cnt == 0 && other_err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("ERROR: watchdog expired after %0d cycles, the run did not complete",
			TEST_CYCLES + MARGIN_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
src/pi_pkg.sv
src/pi_decode_stage.sv
src/pi_access_stage.sv
src/pi_reset_seq.sv
src/pi_soc_top.sv
verif/pi_soc_properties.sv
verif/pi_soc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the peripheral subsystem testbench with Verilator and runs it.
# Exits with a failing status unless the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module pi_soc_tb \
	-f sources.f -o pi_soc_sim || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/pi_soc_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
